// File: src.f
+incdir+design
design/llc_state_pkg.sv
design/llc_lookup_pkg.sv
design/llc_set_if.sv
design/llc_hit_finder.sv
design/llc_victim_picker.sv
design/llc_way_resolver.sv
design/llc_lookup_top.sv
dv/llc_lookup_checker.sv
dv/llc_lookup_tb.sv

// File: run.sh
#!/usr/bin/env bash
# build and run the LLC lookup testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --top-module llc_lookup_tb -f src.f -o llc_lookup_sim

out=$(./obj_dir/llc_lookup_sim)
echo "$out"

if echo "$out" | grep -qx "TESTBENCH PASSED"; then
    exit 0
fi
exit 1

// File: dv/llc_lookup_tb.sv
`timescale 1ns/1ps
`include "llc_params.svh"

module llc_lookup_tb;
    import llc_state_pkg::*;
    import llc_lookup_pkg::*;

    localparam int DEPTH       = `LLC_RSP_DEPTH;
    localparam int NUM_REQ     = 400;
    localparam int STALL_LIMIT = 200;
    localparam int DRAIN_LIMIT = 500;

    logic           clk;
    logic           rst;
    logic           req_valid;
    llc_tag_t       req_tag;
    llc_tag_arr_t   req_tags;
    llc_state_arr_t req_states;
    llc_way_t       req_evict_ptr;
    logic           credit_return;
    logic           rsp_valid;
    logic           rsp_ready;
    llc_way_t       rsp_way;
    logic           rsp_evict;
    logic           rsp_hit;

    int       seed;
    int       credits;
    int       mismatches;
    int       proto_errors;
    int       checked;
    bit       timed_out;
    llc_rsp_t exp_q[$];

    llc_lookup_top llc_lookup_top_i (
        .clk           (clk),
        .rst           (rst),
        .req_valid     (req_valid),
        .req_tag       (req_tag),
        .req_tags      (req_tags),
        .req_states    (req_states),
        .req_evict_ptr (req_evict_ptr),
        .credit_return (credit_return),
        .rsp_valid     (rsp_valid),
        .rsp_ready     (rsp_ready),
        .rsp_way       (rsp_way),
        .rsp_evict     (rsp_evict),
        .rsp_hit       (rsp_hit)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic int rand_below(input int n);
        return int'($unsigned($random(seed)) % n);
    endfunction

    // hit, then invalid, then clean or non-SD way from the pointer, then the pointer
    function automatic llc_rsp_t ref_lookup(input llc_req_t req);
        llc_rsp_t r;
        llc_way_t w;
        for (int i = 0; i < `LLC_WAYS; i++) begin
            if (req.states[i] != INVALID && req.tags[i] == req.tag) begin
                r.way = llc_way_t'(i);
                r.hit = 1'b1;
                r.evict = 1'b0;
                return r;
            end
        end
        r.hit = 1'b0;
        r.evict = 1'b0;
        for (int i = 0; i < `LLC_WAYS; i++) begin
            if (req.states[i] == INVALID) begin
                r.way = llc_way_t'(i);
                return r;
            end
        end
        r.evict = 1'b1;
        for (int k = 0; k < `LLC_WAYS; k++) begin
            w = llc_way_t'((int'(req.evict_ptr) + k) % `LLC_WAYS);
            if (req.states[w] == VALID) begin
                r.way = w;
                return r;
            end
        end
        for (int k = 0; k < `LLC_WAYS; k++) begin
            w = llc_way_t'((int'(req.evict_ptr) + k) % `LLC_WAYS);
            if (req.states[w] != SD) begin
                r.way = w;
                return r;
            end
        end
        r.way = req.evict_ptr;
        return r;
    endfunction

    // biased set mixes so every priority level gets exercised
    task automatic make_set(output llc_req_t req);
        int mode;
        int p;
        mode = rand_below(8);
        req.evict_ptr = llc_way_t'(rand_below(`LLC_WAYS));
        req.tag = (mode == 3 || mode == 4) ? 16'hbeef : llc_tag_t'(rand_below(16));
        for (int i = 0; i < `LLC_WAYS; i++) begin
            req.tags[i] = llc_tag_t'(rand_below(16));
            case (mode)
                0:       req.states[i] = INVALID;
                1:       req.states[i] = SD;
                3:       req.states[i] = llc_state_t'(3'(2 + rand_below(4)));
                4:       req.states[i] = llc_state_t'(3'(1 + rand_below(5)));
                default: req.states[i] = llc_state_t'(3'(rand_below(6)));
            endcase
        end
        if (mode == 2) begin
            // plant the tag in up to two ways
            for (int n = 0; n < 2; n++) begin
                p = rand_below(`LLC_WAYS);
                req.tags[p] = req.tag;
                if (req.states[p] == INVALID) begin
                    req.states[p] = llc_state_t'(3'(1 + rand_below(5)));
                end
            end
        end
    endtask

    task automatic check_way(input string name, input llc_way_t got, input llc_way_t want);
        if (got !== want) begin
            mismatches++;
            $display("CHECK FAILED t=%0t %s got %0d expected %0d", $time, name, got, want);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic want);
        if (got !== want) begin
            mismatches++;
            $display("CHECK FAILED t=%0t %s got %b expected %b", $time, name, got, want);
        end
    endtask

    // one clock of credit collection, random rsp_ready and an optional request
    task automatic tick(input bit want_send, output bit sent);
        llc_req_t req;
        @(posedge clk);
        if (credit_return) begin
            credits++;
        end
        if (credits > DEPTH) begin
            proto_errors++;
            $display("%0t: more credits returned than requests outstanding", $time);
        end
        rsp_ready <= (rand_below(4) != 0);
        sent = 1'b0;
        req_valid <= 1'b0;
        if (want_send && credits > 0) begin
            make_set(req);
            exp_q.push_back(ref_lookup(req));
            req_valid     <= 1'b1;
            req_tag       <= req.tag;
            req_tags      <= req.tags;
            req_states    <= req.states;
            req_evict_ptr <= req.evict_ptr;
            credits--;
            sent = 1'b1;
        end
    endtask

    always @(posedge clk) begin
        llc_rsp_t want;
        if (rst && rsp_valid && rsp_ready) begin
            if (exp_q.size() == 0) begin
                proto_errors++;
                $display("%0t: result arrived with no request outstanding", $time);
            end else begin
                want = exp_q.pop_front();
                check_way("rsp_way", rsp_way, want.way);
                check_flag("rsp_evict", rsp_evict, want.evict);
                check_flag("rsp_hit", rsp_hit, want.hit);
                checked++;
            end
        end
    end

    initial begin
        int  sent_count;
        int  stall;
        bit  sent;
        seed          = 32'he4264115;
        credits       = DEPTH;
        mismatches    = 0;
        proto_errors  = 0;
        checked       = 0;
        timed_out     = 1'b0;
        sent_count    = 0;
        stall         = 0;
        rst           = 1'b0;
        req_valid     = 1'b0;
        req_tag       = '0;
        req_tags      = '0;
        req_states    = '0;
        req_evict_ptr = '0;
        rsp_ready     = 1'b0;
        repeat (3) @(posedge clk);
        rst <= 1'b1;

        while (sent_count < NUM_REQ && !timed_out) begin
            tick(rand_below(4) != 0, sent);
            if (sent) begin
                sent_count++;
                stall = 0;
            end else if (credits == 0) begin
                stall++;
            end
            if (stall > STALL_LIMIT) begin
                timed_out = 1'b1;
                $display("%0t: timeout, no credit came back while waiting to send", $time);
            end
        end

        // drain until every result is taken and every credit is home
        stall = 0;
        while (!timed_out && (exp_q.size() != 0 || credits != DEPTH)) begin
            tick(1'b0, sent);
            stall++;
            if (stall > DRAIN_LIMIT) begin
                timed_out = 1'b1;
                $display("%0t: timeout, results still outstanding after drain", $time);
            end
        end

        // nothing left in the result queue once all credits are home
        if (!timed_out) begin
            check_flag("rsp_valid", rsp_valid, 1'b0);
        end

        $display("results checked %0d, mismatches %0d, protocol errors %0d, timeouts %0d",
                 checked, mismatches, proto_errors, timed_out ? 1 : 0);
        if (mismatches == 0 && proto_errors == 0 && !timed_out) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

// File: dv/llc_lookup_checker.sv
`timescale 1ns/1ps
`include "llc_params.svh"

module llc_lookup_checker (
    input logic clk,
    input logic rst,
    input logic req_valid,
    input logic credit_return,
    input logic rsp_valid,
    input logic rsp_ready,
    input logic rsp_evict,
    input logic rsp_hit
);
    localparam int DEPTH = `LLC_RSP_DEPTH;

    // credits the requester should still hold
    int credits;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            credits <= DEPTH;
        end else begin
            credits <= credits - (req_valid ? 1 : 0) + (credit_return ? 1 : 0);
        end
    end

    no_overdraw: assert property (@(posedge clk) disable iff (!rst)
        req_valid |-> credits > 0)
        else $error("request sent while the requester held no credit");

    evict_not_hit: assert property (@(posedge clk) disable iff (!rst)
        rsp_valid |-> !(rsp_evict && rsp_hit))
        else $error("result flags both evict and hit");

    credit_after_pop: assert property (@(posedge clk) disable iff (!rst)
        (rsp_valid && rsp_ready) |=> credit_return)
        else $error("no credit returned after a result was taken");

    credit_only_on_pop: assert property (@(posedge clk) disable iff (!rst)
        credit_return |-> $past(rsp_valid && rsp_ready))
        else $error("credit returned without a result being taken");

    quiet_after_reset: assert property (@(posedge clk)
        $rose(rst) |-> !rsp_valid && !credit_return)
        else $error("outputs active right after reset release");

endmodule

bind llc_lookup_top llc_lookup_checker lookup_checker_i (
    .clk           (clk),
    .rst           (rst),
    .req_valid     (req_valid),
    .credit_return (credit_return),
    .rsp_valid     (rsp_valid),
    .rsp_ready     (rsp_ready),
    .rsp_evict     (rsp_evict),
    .rsp_hit       (rsp_hit)
);

// File: design/llc_lookup_top.sv
`timescale 1ns/1ps

module llc_lookup_top (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          req_valid,
    input  llc_state_pkg::llc_tag_t       req_tag,
    input  llc_state_pkg::llc_tag_arr_t   req_tags,
    input  llc_state_pkg::llc_state_arr_t req_states,
    input  llc_state_pkg::llc_way_t       req_evict_ptr,
    output logic                          credit_return,
    output logic                          rsp_valid,
    input  logic                          rsp_ready,
    output llc_state_pkg::llc_way_t       rsp_way,
    output logic                          rsp_evict,
    output logic                          rsp_hit
);
    import llc_lookup_pkg::*;

    llc_req_t req_q;
    logic     snap_valid_q;
    llc_rsp_t rsp;

    logic                    hit;
    llc_state_pkg::llc_way_t hit_way;
    logic                    empty_found;
    llc_state_pkg::llc_way_t empty_way;
    logic                    clean_found;
    llc_state_pkg::llc_way_t clean_way;
    logic                    not_sd_found;
    llc_state_pkg::llc_way_t not_sd_way;

    llc_set_if set_bus ();

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            snap_valid_q <= 1'b0;
        end else begin
            snap_valid_q <= req_valid;
        end
    end

    // snapshot payload, only loaded on an accepted request
    always_ff @(posedge clk) begin
        if (req_valid) begin
            req_q.tag       <= req_tag;
            req_q.tags      <= req_tags;
            req_q.states    <= req_states;
            req_q.evict_ptr <= req_evict_ptr;
        end
    end

    assign set_bus.snap_valid = snap_valid_q;
    assign set_bus.tag        = req_q.tag;
    assign set_bus.tags       = req_q.tags;
    assign set_bus.states     = req_q.states;
    assign set_bus.evict_ptr  = req_q.evict_ptr;

    // both searches see the same snapshot
    llc_hit_finder u_hit_finder (
        .set         (set_bus),
        .hit         (hit),
        .hit_way     (hit_way),
        .empty_found (empty_found),
        .empty_way   (empty_way)
    );

    llc_victim_picker u_victim_picker (
        .set          (set_bus),
        .clean_found  (clean_found),
        .clean_way    (clean_way),
        .not_sd_found (not_sd_found),
        .not_sd_way   (not_sd_way)
    );

    llc_way_resolver u_way_resolver (
        .clk           (clk),
        .rst           (rst),
        .set           (set_bus),
        .hit           (hit),
        .hit_way       (hit_way),
        .empty_found   (empty_found),
        .empty_way     (empty_way),
        .clean_found   (clean_found),
        .clean_way     (clean_way),
        .not_sd_found  (not_sd_found),
        .not_sd_way    (not_sd_way),
        .rsp           (rsp),
        .rsp_valid     (rsp_valid),
        .rsp_ready     (rsp_ready),
        .credit_return (credit_return)
    );

    assign rsp_way   = rsp.way;
    assign rsp_evict = rsp.evict;
    assign rsp_hit   = rsp.hit;

endmodule

// File: design/llc_way_resolver.sv
`timescale 1ns/1ps
`include "llc_params.svh"

module llc_way_resolver (
    input  logic                     clk,
    input  logic                     rst,
    llc_set_if.consumer              set,
    input  logic                     hit,
    input  llc_state_pkg::llc_way_t  hit_way,
    input  logic                     empty_found,
    input  llc_state_pkg::llc_way_t  empty_way,
    input  logic                     clean_found,
    input  llc_state_pkg::llc_way_t  clean_way,
    input  logic                     not_sd_found,
    input  llc_state_pkg::llc_way_t  not_sd_way,
    output llc_lookup_pkg::llc_rsp_t rsp,
    output logic                     rsp_valid,
    input  logic                     rsp_ready,
    output logic                     credit_return
);
    import llc_lookup_pkg::*;

    localparam int DEPTH    = `LLC_RSP_DEPTH;
    localparam int PTR_BITS = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_BITS = $clog2(DEPTH + 1);

    llc_rsp_t              result;
    llc_rsp_t              queue [DEPTH];
    logic [PTR_BITS-1:0]   wr_ptr;
    logic [PTR_BITS-1:0]   rd_ptr;
    logic [CNT_BITS-1:0]   count;
    logic                  push;
    logic                  pop;

    function automatic logic [PTR_BITS-1:0] next_ptr(input logic [PTR_BITS-1:0] ptr);
        if (ptr == PTR_BITS'(DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    // hit, then invalid way, then clean victim, then non-SD victim, then pointer
    always_comb begin
        result.hit   = 1'b0;
        result.evict = 1'b1;
        result.way   = set.evict_ptr;
        if (hit) begin
            result.way   = hit_way;
            result.hit   = 1'b1;
            result.evict = 1'b0;
        end else if (empty_found) begin
            result.way   = empty_way;
            result.evict = 1'b0;
        end else if (clean_found) begin
            result.way = clean_way;
        end else if (not_sd_found) begin
            result.way = not_sd_way;
        end
    end

    // credits keep the queue from overflowing
    assign push      = set.snap_valid;
    assign rsp_valid = (count != '0);
    assign pop       = rsp_valid && rsp_ready;
    assign rsp       = queue[rd_ptr];

    always_ff @(posedge clk) begin
        if (push) begin
            queue[wr_ptr] <= result;
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            wr_ptr        <= '0;
            rd_ptr        <= '0;
            count         <= '0;
            credit_return <= 1'b0;
        end else begin
            if (push) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            // one credit back per result taken
            credit_return <= pop;
        end
    end

endmodule

// File: design/llc_victim_picker.sv
`timescale 1ns/1ps
`include "llc_params.svh"

module llc_victim_picker (
    llc_set_if.consumer             set,
    output logic                    clean_found,
    output llc_state_pkg::llc_way_t clean_way,
    output logic                    not_sd_found,
    output llc_state_pkg::llc_way_t not_sd_way
);
    import llc_state_pkg::*;

    llc_state_arr_t rot_states;
    llc_way_mask_t  clean_rot;
    llc_way_mask_t  not_sd_rot;
    llc_way_t       rot_clean_way;
    llc_way_t       rot_not_sd_way;

    // entry 0 of the rotated vector is the way under the pointer
    always_comb begin
        llc_way_t idx;
        for (int i = 0; i < `LLC_WAYS; i++) begin
            idx           = llc_way_t'(i) + set.evict_ptr;
            rot_states[i] = set.states[idx];
        end
    end

    always_comb begin
        for (int i = 0; i < `LLC_WAYS; i++) begin
            clean_rot[i]  = (rot_states[i] == VALID);
            not_sd_rot[i] = (rot_states[i] != SD);
        end
    end

    assign rot_clean_way  = first_way(clean_rot);
    assign rot_not_sd_way = first_way(not_sd_rot);

    // back to absolute way numbers, wraps since the way count is a power of two
    assign clean_way  = rot_clean_way + set.evict_ptr;
    assign not_sd_way = rot_not_sd_way + set.evict_ptr;

    assign clean_found  = |clean_rot;
    assign not_sd_found = |not_sd_rot;

endmodule

// File: design/llc_hit_finder.sv
`timescale 1ns/1ps
`include "llc_params.svh"

module llc_hit_finder (
    llc_set_if.consumer             set,
    output logic                    hit,
    output llc_state_pkg::llc_way_t hit_way,
    output logic                    empty_found,
    output llc_state_pkg::llc_way_t empty_way
);
    import llc_state_pkg::*;

    llc_way_mask_t hit_mask;
    llc_way_mask_t empty_mask;

    always_comb begin
        for (int i = 0; i < `LLC_WAYS; i++) begin
            // an invalid way never hits, whatever its stale tag says
            hit_mask[i]   = (set.tags[i] == set.tag) && (set.states[i] != INVALID);
            empty_mask[i] = (set.states[i] == INVALID);
        end
    end

    // lowest index wins in both searches
    assign hit         = |hit_mask;
    assign hit_way     = first_way(hit_mask);
    assign empty_found = |empty_mask;
    assign empty_way   = first_way(empty_mask);

endmodule

// File: design/llc_set_if.sv
`timescale 1ns/1ps

interface llc_set_if;
    import llc_state_pkg::*;

    logic           snap_valid;
    llc_tag_t       tag;
    llc_tag_arr_t   tags;
    llc_state_arr_t states;
    llc_way_t       evict_ptr;

    // input register side
    modport producer (
        output snap_valid,
        output tag,
        output tags,
        output states,
        output evict_ptr
    );

    // search blocks and resolver
    modport consumer (
        input snap_valid,
        input tag,
        input tags,
        input states,
        input evict_ptr
    );

endinterface

// File: design/llc_lookup_pkg.sv
`include "llc_params.svh"

package llc_lookup_pkg;

    // one set as seen by the lookup
    typedef struct packed {
        llc_state_pkg::llc_tag_t       tag;
        llc_state_pkg::llc_tag_arr_t   tags;
        llc_state_pkg::llc_state_arr_t states;
        llc_state_pkg::llc_way_t       evict_ptr;
    } llc_req_t;

    // evict and hit are never both set
    typedef struct packed {
        llc_state_pkg::llc_way_t way;
        logic                    evict;
        logic                    hit;
    } llc_rsp_t;

endpackage

// File: design/llc_state_pkg.sv
`include "llc_params.svh"

package llc_state_pkg;

    // VALID is clean, SD is shared with data pending
    typedef enum logic [2:0] {
        INVALID   = 3'd0,
        VALID     = 3'd1,
        SHARED    = 3'd2,
        EXCLUSIVE = 3'd3,
        MODIFIED  = 3'd4,
        SD        = 3'd5
    } llc_state_t;

    localparam int WAY_BITS = $clog2(`LLC_WAYS);

    typedef logic [`LLC_TAG_BITS-1:0] llc_tag_t;
    typedef logic [WAY_BITS-1:0] llc_way_t;
    typedef logic [`LLC_WAYS-1:0] llc_way_mask_t;
    typedef llc_tag_t [`LLC_WAYS-1:0] llc_tag_arr_t;
    typedef llc_state_t [`LLC_WAYS-1:0] llc_state_arr_t;

    // lowest set bit of a way mask, 0 when the mask is empty
    function automatic llc_way_t first_way(input llc_way_mask_t mask);
        llc_way_t w;
        w = '0;
        for (int i = `LLC_WAYS - 1; i >= 0; i--) begin
            if (mask[i]) begin
                w = llc_way_t'(i);
            end
        end
        return w;
    endfunction

endpackage

// File: design/llc_params.svh
`ifndef LLC_PARAMS_SVH
`define LLC_PARAMS_SVH

// ways per set, must be a power of two
`define LLC_WAYS 8

// tag width in bits
`define LLC_TAG_BITS 16

// result queue entries, also the requester's initial credits
`define LLC_RSP_DEPTH 2

`endif
